// ==== include/xbar_cfg.svh ====
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Interconnect dimensions
////////////////////////////////////////////////////////////////////////////

// Number of TCDM master ports on the interleaved crossbar
`define XBAR_NUM_MASTERS 4

// Number of word interleaved SRAM banks, kept a power of two
`define XBAR_NUM_BANKS 4

// Bus widths of the TCDM protocol
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

// Start of the interleaved memory region
`define XBAR_REGION_BASE 32'h1C00_0000

// The region spans 64 KiB spread over all banks
`define XBAR_REGION_SIZE 32'h0001_0000

// Read data returned for any access that misses the region
`define XBAR_ERR_WORD 32'hBADACCE5

`endif

// ==== logic/tcdm_bus_pkg.sv ====
`include "xbar_cfg.svh"

package tcdm_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // TCDM bus operation
    ////////////////////////////////////////////////////////////////////////////

    // Follows the TCDM write enable polarity where a high bit means read
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } tcdm_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Request and response channels
    ////////////////////////////////////////////////////////////////////////////

    // Request from a master towards a slave
    // The master holds every field stable while req is high and gnt is low
    typedef struct packed {
        logic                      req;
        tcdm_op_e                  op;
        logic [`XBAR_ADDR_W-1:0]   addr;
        logic [`XBAR_DATA_W-1:0]   wdata;
        logic [`XBAR_DATA_W/8-1:0] be;
    } tcdm_req_t;

    // Response from a slave back to a master
    // The gnt bit belongs to the request cycle, the rest arrives one cycle later
    typedef struct packed {
        logic                    gnt;
        logic                    r_valid;
        // Set when the access ended in a bus error
        logic                    r_opc;
        logic [`XBAR_DATA_W-1:0] r_rdata;
    } tcdm_rsp_t;

endpackage : tcdm_bus_pkg

// ==== logic/xbar_route_pkg.sv ====
`include "xbar_cfg.svh"

package xbar_route_pkg;

    // Index of one SRAM bank
    typedef logic [$clog2(`XBAR_NUM_BANKS)-1:0] bank_idx_t;

    // Index of one master port
    typedef logic [$clog2(`XBAR_NUM_MASTERS)-1:0] mst_idx_t;

    // One bit per master port, used for request and grant masks
    typedef logic [`XBAR_NUM_MASTERS-1:0] mst_vec_t;

    // Where a decoded request is sent
    typedef enum logic {
        TGT_BANK  = 1'b0,
        TGT_ERROR = 1'b1
    } target_e;

    // Decoder result for one master
    typedef struct packed {
        target_e   target;
        bank_idx_t bank;
    } bank_sel_t;

    // Outcome of one bank arbitration in the current cycle
    typedef struct packed {
        logic     valid;
        mst_idx_t winner;
    } bank_grant_t;

endpackage : xbar_route_pkg

// ==== logic/tcdm_addr_decoder.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module tcdm_addr_decoder
    import tcdm_bus_pkg::*;
    import xbar_route_pkg::*;
(
    input  tcdm_req_t [`XBAR_NUM_MASTERS-1:0] mst_req_i,
    output mst_vec_t  [`XBAR_NUM_BANKS-1:0]   bank_req_vec_o,
    output mst_vec_t                          err_req_vec_o
);

    localparam int unsigned NUM_MASTERS = `XBAR_NUM_MASTERS;
    localparam int unsigned NUM_BANKS   = `XBAR_NUM_BANKS;
    localparam int unsigned BANK_W      = $clog2(`XBAR_NUM_BANKS);

    // Byte offset of every request relative to the region base
    logic [`XBAR_ADDR_W-1:0] addr_offset [NUM_MASTERS];

    // Target of every master in this cycle
    bank_sel_t [NUM_MASTERS-1:0] sel;

    ////////////////////////////////////////////////////////////////////////////
    // Region check and bank selection
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_sel
        // Unsigned wrap makes addresses below the base look huge
        assign addr_offset[m] = mst_req_i[m].addr - `XBAR_REGION_BASE;

        // The low word address bits pick the bank so linear streams spread out
        assign sel[m].bank = mst_req_i[m].addr[2 +: BANK_W];

        always_comb begin
            if (addr_offset[m] < `XBAR_REGION_SIZE) begin
                sel[m].target = TGT_BANK;
            end else begin
                sel[m].target = TGT_ERROR;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request spreading
    ////////////////////////////////////////////////////////////////////////////

    // Each requesting master sets exactly one bit across all outputs
    always_comb begin
        bank_req_vec_o = '0;
        err_req_vec_o  = '0;
        for (int unsigned m = 0; m < NUM_MASTERS; m++) begin
            if (mst_req_i[m].req) begin
                if (sel[m].target == TGT_ERROR) begin
                    err_req_vec_o[m] = 1'b1;
                end else begin
                    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
                        if (sel[m].bank == bank_idx_t'(b)) begin
                            bank_req_vec_o[b][m] = 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule : tcdm_addr_decoder

// ==== logic/bank_arbiter.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module bank_arbiter
    import tcdm_bus_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  mst_vec_t                          req_vec_i,
    input  tcdm_req_t [`XBAR_NUM_MASTERS-1:0] mst_req_i,
    input  logic                              bank_gnt_i,
    output tcdm_req_t                         bank_req_o,
    output bank_grant_t                       grant_o
);

    localparam int unsigned NUM_MASTERS = `XBAR_NUM_MASTERS;

    // Master that has the highest priority in the next arbitration
    mst_idx_t rr_ptr_q;

    // Result of the priority search in this cycle
    mst_idx_t winner;
    logic     any_req;

    // Priority moves one past the master just served
    mst_idx_t next_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin search
    ////////////////////////////////////////////////////////////////////////////

    // Walk the masters starting at the pointer and keep the first requester
    always_comb begin
        int unsigned idx;
        any_req = 1'b0;
        winner  = '0;
        for (int unsigned i = 0; i < NUM_MASTERS; i++) begin
            idx = (rr_ptr_q + i) % NUM_MASTERS;
            if (!any_req && req_vec_i[idx]) begin
                any_req = 1'b1;
                winner  = mst_idx_t'(idx);
            end
        end
    end

    assign next_ptr = mst_idx_t'((winner + 1) % NUM_MASTERS);

    ////////////////////////////////////////////////////////////////////////////
    // Request forwarding
    ////////////////////////////////////////////////////////////////////////////

    // The winner's request goes to the bank unchanged
    // With no contender the bank sees an idle request
    always_comb begin
        bank_req_o = '0;
        if (any_req) begin
            bank_req_o     = mst_req_i[winner];
            bank_req_o.req = 1'b1;
        end
    end

    // A transfer only counts once the bank accepts it
    // A low bank gnt stalls every contender of this bank
    assign grant_o.valid  = any_req & bank_gnt_i;
    assign grant_o.winner = winner;

    // Pointer only advances on an accepted transfer so back-pressure keeps the order
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q <= '0;
        end else if (grant_o.valid) begin
            rr_ptr_q <= next_ptr;
        end
    end

endmodule : bank_arbiter

// ==== logic/tcdm_error_slave.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module tcdm_error_slave
    import tcdm_bus_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  mst_vec_t                          err_req_vec_i,
    input  tcdm_req_t [`XBAR_NUM_MASTERS-1:0] mst_req_i,
    output tcdm_rsp_t [`XBAR_NUM_MASTERS-1:0] err_rsp_o
);

    localparam int unsigned NUM_MASTERS = `XBAR_NUM_MASTERS;

    // Masters whose error access was granted in the last cycle
    mst_vec_t valid_q;
    // Operation type of those accesses
    mst_vec_t read_q;

    // Every error access is accepted immediately so nothing waits here
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= err_req_vec_i;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int unsigned m = 0; m < NUM_MASTERS; m++) begin
            if (err_req_vec_i[m]) begin
                read_q[m] <= (mst_req_i[m].op == OP_READ);
            end
        end
    end

    // Reads return the error word, writes only get the flagged acknowledge
    always_comb begin
        for (int unsigned m = 0; m < NUM_MASTERS; m++) begin
            err_rsp_o[m].gnt     = err_req_vec_i[m];
            err_rsp_o[m].r_valid = valid_q[m];
            err_rsp_o[m].r_opc   = valid_q[m];
            err_rsp_o[m].r_rdata = (valid_q[m] && read_q[m]) ? `XBAR_ERR_WORD : '0;
        end
    end

endmodule : tcdm_error_slave

// ==== logic/resp_router.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module resp_router
    import tcdm_bus_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  bank_grant_t [`XBAR_NUM_BANKS-1:0]   grant_i,
    input  tcdm_rsp_t   [`XBAR_NUM_BANKS-1:0]   bank_rsp_i,
    input  tcdm_rsp_t   [`XBAR_NUM_MASTERS-1:0] err_rsp_i,
    output tcdm_rsp_t   [`XBAR_NUM_MASTERS-1:0] mst_rsp_o
);

    localparam int unsigned NUM_MASTERS = `XBAR_NUM_MASTERS;
    localparam int unsigned NUM_BANKS   = `XBAR_NUM_BANKS;

    // Winner of every bank from the previous cycle
    // Banks answer with fixed latency one, so this is all the routing state
    bank_grant_t [NUM_BANKS-1:0] grant_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            grant_q <= '0;
        end else begin
            grant_q <= grant_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response merge
    ////////////////////////////////////////////////////////////////////////////

    // A master has at most one request, so at most one source drives it per cycle
    always_comb begin
        mst_rsp_o = '0;

        // Error slave answers carry their own flag and data
        for (int unsigned m = 0; m < NUM_MASTERS; m++) begin
            mst_rsp_o[m].gnt = err_rsp_i[m].gnt;
            if (err_rsp_i[m].r_valid) begin
                mst_rsp_o[m].r_valid = 1'b1;
                mst_rsp_o[m].r_opc   = err_rsp_i[m].r_opc;
                mst_rsp_o[m].r_rdata = err_rsp_i[m].r_rdata;
            end
        end

        for (int unsigned b = 0; b < NUM_BANKS; b++) begin
            // Grant goes back in the request cycle
            if (grant_i[b].valid) begin
                mst_rsp_o[grant_i[b].winner].gnt = 1'b1;
            end

            // Bank data goes to whoever won the bank one cycle earlier
            // Bank accesses never raise the error flag
            if (grant_q[b].valid && bank_rsp_i[b].r_valid) begin
                mst_rsp_o[grant_q[b].winner].r_valid = 1'b1;
                mst_rsp_o[grant_q[b].winner].r_opc   = 1'b0;
                mst_rsp_o[grant_q[b].winner].r_rdata = bank_rsp_i[b].r_rdata;
            end
        end
    end

endmodule : resp_router

// ==== logic/interleaved_interconnect.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module interleaved_interconnect
    import tcdm_bus_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              reset_i,
    // Master side
    input  tcdm_req_t [`XBAR_NUM_MASTERS-1:0] mst_req_i,
    output tcdm_rsp_t [`XBAR_NUM_MASTERS-1:0] mst_rsp_o,
    // SRAM bank side
    output tcdm_req_t [`XBAR_NUM_BANKS-1:0]   bank_req_o,
    input  tcdm_rsp_t [`XBAR_NUM_BANKS-1:0]   bank_rsp_i
);

    localparam int unsigned NUM_MASTERS = `XBAR_NUM_MASTERS;
    localparam int unsigned NUM_BANKS   = `XBAR_NUM_BANKS;

    // Decoded request masks
    mst_vec_t [NUM_BANKS-1:0] bank_req_vec;
    mst_vec_t                 err_req_vec;

    // Per bank arbitration results
    bank_grant_t [NUM_BANKS-1:0] grant;

    // Error slave answers, one per master
    tcdm_rsp_t [NUM_MASTERS-1:0] err_rsp;

    ////////////////////////////////////////////////////////////////////////////
    // Address check
    ////////////////////////////////////////////////////////////////////////////

    // Every master is restricted to the interleaved region
    // Misses are steered to the error slave
    tcdm_addr_decoder u_decoder (
        .mst_req_i      (mst_req_i),
        .bank_req_vec_o (bank_req_vec),
        .err_req_vec_o  (err_req_vec)
    );

    tcdm_error_slave u_err_slave (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .err_req_vec_i (err_req_vec),
        .mst_req_i     (mst_req_i),
        .err_rsp_o     (err_rsp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Bank arbitration
    ////////////////////////////////////////////////////////////////////////////

    // One combinational round-robin arbiter in front of each bank
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_arbiter
        bank_arbiter u_arbiter (
            .clk_i      (clk_i),
            .reset_i    (reset_i),
            .req_vec_i  (bank_req_vec[b]),
            .mst_req_i  (mst_req_i),
            .bank_gnt_i (bank_rsp_i[b].gnt),
            .bank_req_o (bank_req_o[b]),
            .grant_o    (grant[b])
        );
    end

    // Collects grants now and data one cycle later
    resp_router u_router (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .grant_i    (grant),
        .bank_rsp_i (bank_rsp_i),
        .err_rsp_i  (err_rsp),
        .mst_rsp_o  (mst_rsp_o)
    );

endmodule : interleaved_interconnect

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset drops on a falling edge so it never changes next to a sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule : tb_clock_gen

// ==== bench/tb_interleaved_interconnect.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module tb_interleaved_interconnect
    import tcdm_bus_pkg::*;
    import xbar_route_pkg::*;
();

    localparam int unsigned NUM_MASTERS  = `XBAR_NUM_MASTERS;
    localparam int unsigned NUM_BANKS    = `XBAR_NUM_BANKS;
    localparam int unsigned BANK_W       = $clog2(`XBAR_NUM_BANKS);
    localparam int unsigned PERIOD_NS    = 20;
    localparam int unsigned RESET_CYCLES = 16;
    // Outputs are read a quarter period before the rising edge, long after the falling edge
    localparam int unsigned SAMPLE_NS    = PERIOD_NS / 4;
    // Transfers per master; everything past RAND_XFERS hammers bank 0
    localparam int unsigned XFERS        = 56;
    localparam int unsigned RAND_XFERS   = 40;
    localparam int unsigned WATCHDOG_NS  =
        4 * XFERS * NUM_MASTERS * PERIOD_NS + RESET_CYCLES * PERIOD_NS;

    logic clk;
    logic reset;

    tcdm_req_t [NUM_MASTERS-1:0] mst_req;
    tcdm_rsp_t [NUM_MASTERS-1:0] mst_rsp;
    tcdm_req_t [NUM_BANKS-1:0]   bank_req;
    tcdm_rsp_t [NUM_BANKS-1:0]   bank_rsp;

    // Storage behind each bank port, indexed by the word inside the bank
    logic [31:0] bank_mem [NUM_BANKS][4096];
    // Expected contents of every written address, keyed by byte address
    logic [31:0] ref_mem [logic [31:0]];
    int unsigned xfers_done;

    // Flattened handshake bits for the property checks
    mst_vec_t             mst_gnt;
    mst_vec_t             mst_rvalid;
    logic [NUM_BANKS-1:0] bank_req_bits;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    interleaved_interconnect u_interleaved_interconnect (
        .clk_i      (clk),
        .reset_i    (reset),
        .mst_req_i  (mst_req),
        .mst_rsp_o  (mst_rsp),
        .bank_req_o (bank_req),
        .bank_rsp_i (bank_rsp)
    );

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            mst_gnt[i]    = mst_rsp[i].gnt;
            mst_rvalid[i] = mst_rsp[i].r_valid;
        end
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_req_bits[i] = bank_req[i].req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and reference rules
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1, "Value check failed");
    endtask

    task automatic report_failure(input string what);
        $display("%s at time %0t", what, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "Protocol check failed");
    endtask

    function automatic logic in_region(input logic [31:0] addr);
        return (addr >= `XBAR_REGION_BASE) &&
               (addr < `XBAR_REGION_BASE + `XBAR_REGION_SIZE);
    endfunction

    // Power-on contents, scrambled from every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr * 32'h9E37_79B9 ^ 32'h5A5A_5A5A;
    endfunction

    // Bytes with a set enable take the new data, the others keep the old word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        for (int k = 0; k < 4; k++) begin
            mask[8*k +: 8] = {8{be[k]}};
        end
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    function automatic tcdm_req_t make_request(input logic hot);
        tcdm_req_t r;
        r.req   = 1'b1;
        r.op    = ($urandom_range(0, 1) != 0) ? OP_READ : OP_WRITE;
        r.wdata = $urandom;
        r.be    = 4'($urandom_range(1, 15));
        if (hot) begin
            // Word stride of four banks keeps every access on bank 0
            r.addr = `XBAR_REGION_BASE + ($urandom_range(0, 15) << 4);
        end else if ($urandom_range(0, 7) == 0) begin
            r.addr = ($urandom_range(0, 1) != 0) ?
                `XBAR_REGION_BASE + `XBAR_REGION_SIZE + ($urandom_range(0, 255) << 2) :
                `XBAR_REGION_BASE - 4 - ($urandom_range(0, 255) << 2);
        end else begin
            // A small window so reads often hit earlier writes
            r.addr = `XBAR_REGION_BASE + ($urandom_range(0, 63) << 2);
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bank models and masters
    ////////////////////////////////////////////////////////////////////////////

    // Grants three cycles in four and answers one cycle after each transfer
    task automatic run_bank(input bank_idx_t b);
        logic        pend;
        logic [31:0] data;
        logic [11:0] widx;
        pend = 1'b0;
        data = '0;
        for (int unsigned w = 0; w < 4096; w++) begin
            bank_mem[b][12'(w)] = fill_word(`XBAR_REGION_BASE + (w << 4) + (32'(b) << 2));
        end
        forever begin
            @(negedge clk);
            bank_rsp[b].gnt     = ($urandom_range(0, 3) != 0);
            bank_rsp[b].r_valid = pend;
            bank_rsp[b].r_rdata = data;
            #(SAMPLE_NS);
            pend = bank_req[b].req && bank_rsp[b].gnt;
            if (pend) begin
                widx = bank_req[b].addr[15:4];
                data = bank_mem[b][widx];
                if (bank_req[b].op == OP_WRITE) begin
                    bank_mem[b][widx] = merge_bytes(data, bank_req[b].wdata,
                                                    bank_req[b].be);
                end
            end
        end
    endtask

    task automatic check_response(input mst_idx_t m, input logic exp_err,
                                  input logic exp_read, input logic [31:0] exp_data);
        assert (mst_rsp[m].r_valid)
            else report_mismatch($sformatf("mst_rsp_o[%0d].r_valid", m), 32'd1, 32'd0);
        assert (mst_rsp[m].r_opc == exp_err)
            else report_mismatch($sformatf("mst_rsp_o[%0d].r_opc", m), 32'(exp_err),
                                 32'(mst_rsp[m].r_opc));
        if (exp_read) begin
            assert (mst_rsp[m].r_rdata == exp_data)
                else report_mismatch($sformatf("mst_rsp_o[%0d].r_rdata", m), exp_data,
                                     mst_rsp[m].r_rdata);
        end
    endtask

    task automatic run_master(input mst_idx_t m);
        tcdm_req_t   req;
        logic        req_err;
        logic        pend;
        logic        exp_err;
        logic        exp_read;
        logic [31:0] exp_data;
        bank_idx_t   bank;
        int unsigned waited;
        pend = 1'b0;
        exp_err = 1'b0;
        exp_read = 1'b0;
        exp_data = '0;
        for (int unsigned n = 0; n < XFERS; n++) begin
            req = make_request(n >= RAND_XFERS);
            req_err = !in_region(req.addr);
            bank = req.addr[2 +: BANK_W];
            waited = 0;
            @(negedge clk);
            mst_req[m] = req;
            #(SAMPLE_NS);
            // The previous transfer answers in the first cycle of this request
            if (pend) begin
                check_response(m, exp_err, exp_read, exp_data);
            end
            if (req_err) begin
                assert (mst_rsp[m].gnt)
                    else report_mismatch($sformatf("mst_rsp_o[%0d].gnt", m), 32'd1, 32'd0);
            end
            forever begin
                if (!req_err && !bank_rsp[bank].gnt) begin
                    assert (!mst_rsp[m].gnt)
                        else report_mismatch($sformatf("mst_rsp_o[%0d].gnt", m), 32'd0, 32'd1);
                end
                if (mst_rsp[m].gnt) break;
                if (!req_err && bank_req[bank].req && bank_rsp[bank].gnt) waited++;
                assert (waited < NUM_MASTERS)
                    else report_failure($sformatf("Master %0d starved on bank %0d", m, bank));
                @(negedge clk);
                #(SAMPLE_NS);
            end
            // Bank order and reference order agree since one bank serves one master a cycle
            exp_err  = req_err;
            exp_read = (req.op == OP_READ);
            if (exp_err) begin
                exp_data = 32'hBADACCE5;
            end else begin
                exp_data = ref_mem.exists(req.addr) ? ref_mem[req.addr] : fill_word(req.addr);
                if (!exp_read) ref_mem[req.addr] = merge_bytes(exp_data, req.wdata, req.be);
            end
            pend = 1'b1;
            xfers_done++;
            if (n < RAND_XFERS && $urandom_range(0, 3) == 0) begin
                @(negedge clk);
                mst_req[m] = '0;
                #(SAMPLE_NS);
                check_response(m, exp_err, exp_read, exp_data);
                pend = 1'b0;
            end
        end
        @(negedge clk);
        mst_req[m] = '0;
        #(SAMPLE_NS);
        if (pend) check_response(m, exp_err, exp_read, exp_data);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Property checks
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) reset |=> ({mst_gnt, mst_rvalid, bank_req_bits} == '0))
        else report_mismatch("mst gnt, r_valid and bank req", 32'd0,
                             32'({mst_gnt, mst_rvalid, bank_req_bits}));

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_mst_checks
        assert property (@(posedge clk) disable iff (reset) mst_gnt[m] |=> mst_rvalid[m])
            else report_mismatch($sformatf("mst_rsp_o[%0d].r_valid", m), 32'd1, 32'd0);
        assert property (@(posedge clk) disable iff (reset) !mst_gnt[m] |=> !mst_rvalid[m])
            else report_mismatch($sformatf("mst_rsp_o[%0d].r_valid", m), 32'd0, 32'd1);
        assert property (@(posedge clk) disable iff (reset)
            (mst_req[m].req && !mst_gnt[m]) |=> (mst_req[m] == $past(mst_req[m])))
            else report_failure($sformatf("Master %0d changed a request still waiting", m));
    end

    // Each bank only sees in-region words whose low word bits name it
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank_checks
        assert property (@(posedge clk) disable iff (reset)
            bank_req[b].req |-> (bank_req[b].addr[2 +: BANK_W] == bank_idx_t'(b)))
            else report_mismatch($sformatf("bank_req_o[%0d].addr bank bits", b), 32'(b),
                                 32'(bank_req[b].addr[2 +: BANK_W]));
        assert property (@(posedge clk) disable iff (reset)
            bank_req[b].req |-> in_region(bank_req[b].addr))
            else report_failure($sformatf("Bank %0d saw an out-of-region access", b));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d transfers done", WATCHDOG_NS,
                 xfers_done);
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        mst_req = '0;
        bank_rsp = '0;
        xfers_done = 0;
        void'($urandom(32'h2765));
        fork
            run_bank(bank_idx_t'(0));
            run_bank(bank_idx_t'(1));
            run_bank(bank_idx_t'(2));
            run_bank(bank_idx_t'(3));
        join_none
        @(negedge reset);
        fork
            run_master(mst_idx_t'(0));
            run_master(mst_idx_t'(1));
            run_master(mst_idx_t'(2));
            run_master(mst_idx_t'(3));
        join
        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_interleaved_interconnect

// ==== filelist.f ====
+incdir+include
logic/tcdm_bus_pkg.sv
logic/xbar_route_pkg.sv
logic/tcdm_addr_decoder.sv
logic/bank_arbiter.sv
logic/tcdm_error_slave.sv
logic/resp_router.sv
logic/interleaved_interconnect.sv
bench/tb_clock_gen.sv
bench/tb_interleaved_interconnect.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the interconnect testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_interleaved_interconnect
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" \
    -f filelist.f -Mdir "$OBJ" -o sim_bin
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/sim_bin" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

# The log decides the verdict
if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0
